//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module operandFetch_tb -f sim.f -o simv
	./obj_dir/simv > sim.log 2>&1 || true
	cat sim.log
	@if grep -q '>>> FAIL' sim.log || ! grep -q '>>> PASS' sim.log; then \
		echo "simulation failed, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- hdl/dispatchReg.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvIssue_params.svh"

module dispatchReg (
    input  var logic                 clk,
    input  var logic                 rst,
    input  var logic                 rdy,
    input  var logic                 clr,
    input  var logic                 accept,
    input  var rvIssuePkg::opClass_t op,
    input  var rvIssuePkg::regName_t rd,
    input  var rvIssuePkg::data_t    imm,
    input  var rvIssuePkg::data_t    pc,
    input  var rvIssuePkg::data_t    rs1Val,
    input  var rvIssuePkg::tag_t     rs1Tag,
    input  var rvIssuePkg::data_t    rs2Val,
    input  var rvIssuePkg::tag_t     rs2Tag,
    input  var rvIssuePkg::tag_t     newTag,
    input  var logic                 commitEn,
    input  var rvIssuePkg::tag_t     commitTag,
    input  var rvIssuePkg::data_t    commitData,
    output logic                     dispEn,
    output rvIssuePkg::opClass_t     dispOp,
    output rvIssuePkg::regName_t     dispRd,
    output rvIssuePkg::data_t        dispImm,
    output rvIssuePkg::data_t        dispPc,
    output rvIssuePkg::data_t        dispRs1Val,
    output rvIssuePkg::tag_t         dispRs1Tag,
    output rvIssuePkg::data_t        dispRs2Val,
    output rvIssuePkg::tag_t         dispRs2Tag,
    output rvIssuePkg::tag_t         dispTag
);
    import rvIssuePkg::*;

    logic rs1Hit;
    logic rs2Hit;

    // the register file only sees this commit at the edge, so forward it here.
    assign rs1Hit = commitEn && rdy && (rs1Tag != '0) && (rs1Tag == commitTag);
    assign rs2Hit = commitEn && rdy && (rs2Tag != '0) && (rs2Tag == commitTag);

    always_ff @(posedge clk) begin
        if (rst) begin
            dispEn <= 1'b0;
        end else begin
            dispEn <= accept && rdy && !clr;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dispOp     <= op;
            dispRd     <= rd;
            dispImm    <= imm;
            dispPc     <= pc;
            dispTag    <= newTag;
            dispRs1Val <= rs1Hit ? commitData : rs1Val;
            dispRs1Tag <= rs1Hit ? '0 : rs1Tag;
            dispRs2Val <= rs2Hit ? commitData : rs2Val;
            dispRs2Tag <= rs2Hit ? '0 : rs2Tag;
        end
    end

endmodule

`default_nettype wire

//--- hdl/instDecode.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvIssue_params.svh"

module instDecode (
    input  var rvIssuePkg::instWord_t instWord,
    output rvIssuePkg::regName_t      rs1,
    output rvIssuePkg::regName_t      rs2,
    output rvIssuePkg::regName_t      rd,
    output rvIssuePkg::opClass_t      opClass,
    output rvIssuePkg::data_t         imm,
    output logic                      writesRd
);
    import rvIssuePkg::*;

    localparam logic [6:0] opcAlu    = 7'b0110011;
    localparam logic [6:0] opcAluI   = 7'b0010011;
    localparam logic [6:0] opcLoad   = 7'b0000011;
    localparam logic [6:0] opcStore  = 7'b0100011;
    localparam logic [6:0] opcBranch = 7'b1100011;

    data_t immI;
    data_t immS;
    data_t immB;

    // I-type takes bits 31 to 20, which sit in funct7 and rs2 of the R view.
    assign immI = {{(`XLEN-12){instWord.rView.funct7[6]}},
                   instWord.rView.funct7, instWord.rView.rs2};
    assign immS = {{(`XLEN-12){instWord.sView.immHi[6]}},
                   instWord.sView.immHi, instWord.sView.immLo};
    // branch offsets are even, so bit 0 is implied.
    assign immB = {{(`XLEN-13){instWord.sView.immHi[6]}},
                   instWord.sView.immHi[6], instWord.sView.immLo[0],
                   instWord.sView.immHi[5:0], instWord.sView.immLo[4:1], 1'b0};

    assign rd = instWord.rView.rd;

    always_comb begin
        opClass = OP_ILLEGAL;
        imm     = '0;
        rs1     = '0;
        rs2     = '0;
        case (instWord.rView.opcode)
            opcAlu: begin
                opClass = OP_ALU;
                rs1     = instWord.rView.rs1;
                rs2     = instWord.rView.rs2;
            end
            opcAluI: begin
                opClass = OP_ALUI;
                imm     = immI;
                rs1     = instWord.rView.rs1;
            end
            opcLoad: begin
                opClass = OP_LOAD;
                imm     = immI;
                rs1     = instWord.rView.rs1;
            end
            opcStore: begin
                opClass = OP_STORE;
                imm     = immS;
                rs1     = instWord.sView.rs1;
                rs2     = instWord.sView.rs2;
            end
            opcBranch: begin
                opClass = OP_BRANCH;
                imm     = immB;
                rs1     = instWord.sView.rs1;
                rs2     = instWord.sView.rs2;
            end
            default: opClass = OP_ILLEGAL; // sources stay at x0.
        endcase
    end

    // only results that land in a real register need a rename.
    assign writesRd = (opClass == OP_ALU || opClass == OP_ALUI || opClass == OP_LOAD) &&
                      (rd != '0);

endmodule

`default_nettype wire

//--- hdl/operandFetch.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvIssue_params.svh"

module operandFetch (
    input  var logic                  clk,
    input  var logic                  rst,
    input  var logic                  rdy,
    input  var logic                  clr,
    input  var logic                  instEn,
    input  var rvIssuePkg::instWord_t instWord,
    input  var rvIssuePkg::data_t     instPc,
    input  var logic                  commitEn,
    input  var rvIssuePkg::tag_t      commitTag,
    input  var rvIssuePkg::data_t     commitData,
    output logic                      stall,
    output logic                      dispEn,
    output rvIssuePkg::opClass_t      dispOp,
    output rvIssuePkg::regName_t      dispRd,
    output rvIssuePkg::data_t         dispImm,
    output rvIssuePkg::data_t         dispPc,
    output rvIssuePkg::data_t         dispRs1Val,
    output rvIssuePkg::tag_t          dispRs1Tag,
    output rvIssuePkg::data_t         dispRs2Val,
    output rvIssuePkg::tag_t          dispRs2Tag,
    output rvIssuePkg::tag_t          dispTag
);
    import rvIssuePkg::*;

    regName_t rs1, rs2, rd;
    opClass_t opClass;
    data_t    imm;
    logic     writesRd;
    data_t    rs1Val, rs2Val;
    tag_t     rs1Tag, rs2Tag;
    tag_t     nextTag;
    logic     accept;
    logic     renameEn;

    assign accept   = instEn && rdy && !stall && !clr; // the source holds while stalled.
    assign renameEn = accept && writesRd;

    instDecode u_instDecode (
        .instWord, .rs1, .rs2, .rd, .opClass, .imm, .writesRd
    );

    regFile u_regFile (
        .clk, .rst, .rdy, .clr, .rs1, .rs2, .rs1Val, .rs2Val, .rs1Tag, .rs2Tag,
        .renameEn, .renameRd(rd), .renameTag(nextTag), .commitEn, .commitTag, .commitData
    );

    tagAlloc u_tagAlloc (
        .clk, .rst, .rdy, .clr, .allocEn(accept), .commitEn, .nextTag, .stall
    );

    dispatchReg u_dispatchReg (
        .clk, .rst, .rdy, .clr, .accept, .op(opClass), .rd, .imm, .pc(instPc),
        .rs1Val, .rs1Tag, .rs2Val, .rs2Tag, .newTag(nextTag),
        .commitEn, .commitTag, .commitData,
        .dispEn, .dispOp, .dispRd, .dispImm, .dispPc,
        .dispRs1Val, .dispRs1Tag, .dispRs2Val, .dispRs2Tag, .dispTag
    );

endmodule

`default_nettype wire

//--- hdl/regFile.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvIssue_params.svh"

module regFile (
    input  var logic                 clk,
    input  var logic                 rst,
    input  var logic                 rdy,
    input  var logic                 clr,
    input  var rvIssuePkg::regName_t rs1,
    input  var rvIssuePkg::regName_t rs2,
    output rvIssuePkg::data_t        rs1Val,
    output rvIssuePkg::data_t        rs2Val,
    output rvIssuePkg::tag_t         rs1Tag,
    output rvIssuePkg::tag_t         rs2Tag,
    input  var logic                 renameEn,
    input  var rvIssuePkg::regName_t renameRd,
    input  var rvIssuePkg::tag_t     renameTag,
    input  var logic                 commitEn,
    input  var rvIssuePkg::tag_t     commitTag,
    input  var rvIssuePkg::data_t    commitData
);
    import rvIssuePkg::*;

    data_t regVal [`REG_NUM];
    tag_t  regTag [`REG_NUM];

    logic commitOk;
    logic renameOk;

    // a commit during clr still lands its value.
    assign commitOk = commitEn && (rdy || clr) && (commitTag != '0);
    assign renameOk = renameEn && rdy && !clr && (renameRd != '0);

    always_comb begin
        rs1Val = (rs1 == '0) ? '0 : regVal[rs1];
        rs1Tag = (rs1 == '0) ? '0 : regTag[rs1];
        rs2Val = (rs2 == '0) ? '0 : regVal[rs2];
        rs2Tag = (rs2 == '0) ? '0 : regTag[rs2];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regVal[i] <= '0;
                regTag[i] <= '0;
            end
        end else begin
            // the commit port has no register name, so match on the pending tag.
            for (int i = 1; i < `REG_NUM; i++) begin
                if (commitOk && regTag[i] == commitTag) begin
                    regVal[i] <= commitData;
                    regTag[i] <= '0;
                end
            end
            if (renameOk) begin
                regTag[renameRd] <= renameTag; // a rename overrides the clear above.
            end
            if (clr) begin
                for (int i = 0; i < `REG_NUM; i++) begin
                    regTag[i] <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/rvIssuePkg.sv
`default_nettype none

`include "rvIssue_params.svh"

package rvIssuePkg;

    typedef logic [4:0]        regName_t;
    typedef logic [`TAG_W-1:0] tag_t;     // zero marks a ready register.
    typedef logic [`XLEN-1:0]  data_t;

    typedef enum logic [2:0] {
        OP_ALU,
        OP_ALUI,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_ILLEGAL
    } opClass_t;

    typedef struct packed {
        logic [6:0] funct7;
        regName_t   rs2;
        regName_t   rs1;
        logic [2:0] funct3;
        regName_t   rd;
        logic [6:0] opcode;
    } rView_t;

    typedef struct packed {
        logic [6:0] immHi;
        regName_t   rs2;
        regName_t   rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;  // the rd slot carries low immediate bits here.
        logic [6:0] opcode;
    } sView_t;

    typedef union packed {
        rView_t rView;
        sView_t sView;
    } instWord_t;

endpackage

`default_nettype wire

//--- hdl/rvIssue_params.svh
`ifndef RV_ISSUE_PARAMS_SVH
`define RV_ISSUE_PARAMS_SVH

// data path width of the core.
`define XLEN 32

// architectural registers, x0 included.
`define REG_NUM 32

`define TAG_W 4 // width of a rename tag.

// usable reorder tags run from 1 to TAG_POOL and tag 0 means ready.
`define TAG_POOL 15

`endif

//--- hdl/tagAlloc.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvIssue_params.svh"

module tagAlloc (
    input  var logic             clk,
    input  var logic             rst,
    input  var logic             rdy,
    input  var logic             clr,
    input  var logic             allocEn,
    input  var logic             commitEn,
    output rvIssuePkg::tag_t     nextTag,
    output logic                 stall
);
    import rvIssuePkg::*;

    localparam int cntWidth = $clog2(`TAG_POOL + 1);

    tag_t                head;
    logic [cntWidth-1:0] count;
    logic                allocOk;
    logic                commitOk;

    assign allocOk  = allocEn && rdy && !clr;
    assign commitOk = commitEn && rdy && !clr; // commits retire the oldest tag.

    assign nextTag = head;
    assign stall   = (count == cntWidth'(`TAG_POOL));

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            head  <= tag_t'(1);
            count <= '0;
        end else begin
            if (allocOk) begin
                head <= (head == tag_t'(`TAG_POOL)) ? tag_t'(1) : head + tag_t'(1);
            end
            case ({allocOk, commitOk})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+hdl
hdl/rvIssuePkg.sv
hdl/instDecode.sv
hdl/regFile.sv
hdl/tagAlloc.sv
hdl/dispatchReg.sv
hdl/operandFetch.sv
tests/operandFetch_asserts.sv
tests/operandFetch_tb.sv

//--- tests/operandFetch_asserts.sv
`timescale 1ns/1ns
`default_nettype none

`include "rvIssue_params.svh"

module operandFetch_asserts (
    input var logic                              clk,
    input var logic                              rst,
    input var logic                              rdy,
    input var logic                              clr,
    input var logic                              commitEn,
    input var logic                              stall,
    input var logic                              dispEn,
    input var logic [$clog2(`TAG_POOL + 1)-1:0] inFlight
);

    noDispAfterIdle: assert property (@(posedge clk) disable iff (rst)
        (clr || !rdy) |=> !dispEn)
        else $error("dispEn high in the cycle after clr or rdy low");

    // commits retire the oldest tag, so one must be in flight.
    commitNeedsTag: assert property (@(posedge clk) disable iff (rst)
        commitEn |-> (inFlight != '0))
        else $error("commitEn arrived with no tag in flight");

    stallHolds: assert property (@(posedge clk) disable iff (rst)
        (inFlight == `TAG_POOL && !(commitEn && rdy) && !clr) |=> stall)
        else $error("stall dropped while the tag pool stayed full");

endmodule

bind operandFetch operandFetch_asserts u_asserts (
    .clk, .rst, .rdy, .clr, .commitEn, .stall, .dispEn,
    .inFlight(u_tagAlloc.count)
);

`default_nettype wire

//--- tests/operandFetch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module operandFetch_tb;
    import rvIssuePkg::*;

    localparam int clkPeriod = 100;

    logic      clk;
    logic      rst;
    logic      rdy;
    logic      clr;
    logic      instEn;
    instWord_t instWord;
    data_t     instPc;
    logic      commitEn;
    tag_t      commitTag;
    data_t     commitData;

    logic      stall;
    logic      dispEn;
    opClass_t  dispOp;
    regName_t  dispRd;
    data_t     dispImm;
    data_t     dispPc;
    data_t     dispRs1Val;
    tag_t      dispRs1Tag;
    data_t     dispRs2Val;
    tag_t      dispRs2Tag;
    tag_t      dispTag;

    string lines [$];
    int    vecCount = 0;

    // the fields of one parsed vector line in file order.
    logic       fRdy, fClr, fInstEn, fCommitEn, fStall, fEn;
    data_t      fWord, fPc, fCommitData, fImm, fDispPc, fRs1Val, fRs2Val;
    tag_t       fCommitTag, fRs1Tag, fRs2Tag, fTag;
    logic [2:0] fOp;
    regName_t   fRd;

    operandFetch u_operandFetch (
        .clk, .rst, .rdy, .clr, .instEn, .instWord, .instPc,
        .commitEn, .commitTag, .commitData, .stall,
        .dispEn, .dispOp, .dispRd, .dispImm, .dispPc,
        .dispRs1Val, .dispRs1Tag, .dispRs2Val, .dispRs2Tag, .dispTag
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped after the first error");
    endtask

    task automatic checkBit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            abortRun($sformatf("mismatch at %0t ns: %s is %b, expected %b",
                               $time, name, got, exp));
        end
    endtask

    task automatic checkOp(input opClass_t got, input opClass_t exp, input string name);
        if (got !== exp) begin
            abortRun($sformatf("mismatch at %0t ns: %s is %0d, expected %0d",
                               $time, name, got, exp));
        end
    endtask

    task automatic checkReg(input regName_t got, input regName_t exp, input string name);
        if (got !== exp) begin
            abortRun($sformatf("mismatch at %0t ns: %s is x%0d, expected x%0d",
                               $time, name, got, exp));
        end
    endtask

    task automatic checkData(input data_t got, input data_t exp, input string name);
        if (got !== exp) begin
            abortRun($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic checkTag(input tag_t got, input tag_t exp, input string name);
        if (got !== exp) begin
            abortRun($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic loadVectors();
        int    fd;
        string line;
        fd = $fopen("tests/operandFetch_vectors.txt", "r");
        if (fd == 0) begin
            abortRun("could not open tests/operandFetch_vectors.txt for reading");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.substr(0, 1) != "//") begin
                lines.push_back(line); // comment and blank lines are skipped.
            end
        end
        $fclose(fd);
        if (lines.size() == 0) begin
            abortRun("the vector file holds no vectors");
        end
        vecCount = lines.size();
    endtask

    task automatic readFields(input int idx);
        int n;
        n = $sscanf(lines[idx], "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    fRdy, fClr, fInstEn, fWord, fPc, fCommitEn, fCommitTag, fCommitData,
                    fStall, fEn, fOp, fRd, fImm, fDispPc, fRs1Val, fRs1Tag, fRs2Val,
                    fRs2Tag, fTag);
        if (n != 19) begin
            abortRun($sformatf("vector %0d has %0d fields instead of 19", idx + 1, n));
        end
    endtask

    // the other packet fields hold their old values when dispEn is low.
    task automatic checkDispatch();
        checkBit(dispEn, fEn, "dispEn");
        if (fEn) begin
            checkOp(dispOp, opClass_t'(fOp), "dispOp");
            checkReg(dispRd, fRd, "dispRd");
            checkData(dispImm, fImm, "dispImm");
            checkData(dispPc, fDispPc, "dispPc");
            checkData(dispRs1Val, fRs1Val, "dispRs1Val");
            checkTag(dispRs1Tag, fRs1Tag, "dispRs1Tag");
            checkData(dispRs2Val, fRs2Val, "dispRs2Val");
            checkTag(dispRs2Tag, fRs2Tag, "dispRs2Tag");
            checkTag(dispTag, fTag, "dispTag");
        end
    endtask

    initial begin
        wait (vecCount > 0);
        #((vecCount + 12) * clkPeriod);
        abortRun("the run hung, the vectors did not finish before the timeout");
    end

    initial begin
        rst        = 1'b1;
        rdy        = 1'b0;
        clr        = 1'b0;
        instEn     = 1'b0;
        instWord   = '0;
        instPc     = '0;
        commitEn   = 1'b0;
        commitTag  = '0;
        commitData = '0;
        loadVectors();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i <= vecCount; i++) begin
            @(posedge clk);
            if (i < vecCount) begin
                readFields(i);
                rdy        <= fRdy;
                clr        <= fClr;
                instEn     <= fInstEn;
                instWord   <= fWord;
                instPc     <= fPc;
                commitEn   <= fCommitEn;
                commitTag  <= fCommitTag;
                commitData <= fCommitData;
            end else begin
                clr      <= 1'b0;
                instEn   <= 1'b0;
                commitEn <= 1'b0;
            end
            @(negedge clk);
            if (i < vecCount) begin
                checkBit(stall, fStall, "stall"); // stall decides whether line i is taken.
            end
            if (i == 0) begin
                checkBit(dispEn, 1'b0, "dispEn");
            end else begin
                readFields(i - 1); // outputs now show the packet of the previous line.
                checkDispatch();
            end
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/operandFetch_vectors.txt
// rdy clr instEn instWord instPc commitEn commitTag commitData stall, then
// expected after the next edge: dispEn op rd imm pc rs1Val rs1Tag rs2Val rs2Tag tag
1 0 1 ffb00093 00001000 0 0 00000000 0 1 1 01 fffffffb 00001000 00000000 0 00000000 0 1
1 0 1 00108133 00001004 0 0 00000000 0 1 0 02 00000000 00001004 00000000 1 00000000 1 2
1 0 1 7ff12183 00001008 0 0 00000000 0 1 2 03 000007ff 00001008 00000000 2 00000000 0 3
1 0 1 fe30ae23 0000100c 0 0 00000000 0 1 3 1c fffffffc 0000100c 00000000 1 00000000 3 4
1 0 1 fe220ce3 00001010 0 0 00000000 0 1 4 19 fffffff8 00001010 00000000 0 00000000 2 5
1 0 1 deadbeef 00001014 0 0 00000000 0 1 5 1d 00000000 00001014 00000000 0 00000000 0 6
1 0 1 000e02b3 00001018 0 0 00000000 0 1 0 05 00000000 00001018 00000000 0 00000000 0 7
1 0 1 00108093 0000101c 0 0 00000000 0 1 1 01 00000001 0000101c 00000000 1 00000000 0 8
1 0 1 00508333 00001020 0 0 00000000 0 1 0 06 00000000 00001020 00000000 8 00000000 7 9
1 0 1 12300393 00001024 0 0 00000000 0 1 1 07 00000123 00001024 00000000 0 00000000 0 a
1 0 1 12300393 00001028 0 0 00000000 0 1 1 07 00000123 00001028 00000000 0 00000000 0 b
1 0 1 12300393 0000102c 0 0 00000000 0 1 1 07 00000123 0000102c 00000000 0 00000000 0 c
1 0 1 12300393 00001030 0 0 00000000 0 1 1 07 00000123 00001030 00000000 0 00000000 0 d
1 0 1 12300393 00001034 0 0 00000000 0 1 1 07 00000123 00001034 00000000 0 00000000 0 e
1 0 1 12300393 00001038 0 0 00000000 0 1 1 07 00000123 00001038 00000000 0 00000000 0 f
1 0 1 00638433 0000103c 0 0 00000000 1 0 0 00 00000000 00000000 00000000 0 00000000 0 0
1 0 1 00638433 0000103c 1 1 11111111 1 0 0 00 00000000 00000000 00000000 0 00000000 0 0
1 0 1 00638433 0000103c 0 0 00000000 0 1 0 08 00000000 0000103c 00000000 f 00000000 9 1
1 0 0 00000000 00000000 1 2 22222222 1 0 0 00 00000000 00000000 00000000 0 00000000 0 0
1 0 1 002184b3 00001040 1 3 33333333 0 1 0 09 00000000 00001040 33333333 0 22222222 0 2
1 0 1 00118533 00001044 1 4 44444444 0 1 0 0a 00000000 00001044 33333333 0 00000000 8 3
0 0 1 001285b3 00001048 1 5 55555555 0 0 0 00 00000000 00000000 00000000 0 00000000 0 0
1 0 1 001285b3 00001048 1 5 55555555 0 1 0 0b 00000000 00001048 00000000 7 00000000 8 4
1 0 0 00000000 00000000 1 6 66666666 0 0 0 00 00000000 00000000 00000000 0 00000000 0 0
1 1 1 00128633 0000104c 1 7 77777777 0 0 0 00 00000000 00000000 00000000 0 00000000 0 0
1 0 1 00128633 0000104c 0 0 00000000 0 1 0 0c 00000000 0000104c 77777777 0 00000000 0 1
1 0 1 009606b3 00001050 0 0 00000000 0 1 0 0d 00000000 00001050 00000000 1 00000000 0 2
1 0 1 00c60733 00001054 1 1 aaaa5555 0 1 0 0e 00000000 00001054 aaaa5555 0 aaaa5555 0 3
